//--- loong_decode.f
verilog/decode_pkg.sv
verilog/decode_if.sv
verilog/instr_fifo.sv
verilog/decoder_csr.sv
verilog/decoder_alu_3r.sv
verilog/decoder_alu_2ri12.sv
verilog/decode_stage.sv
verilog/loong_decode_top.sv
testbench/tb_loong_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_loong_decode -f loong_decode.f -o sim_tb > "$LOG" 2>&1 \
    || { echo "Build failed, see $LOG"; exit 1; }

./obj_dir/sim_tb >> "$LOG" 2>&1

# The log decides, since a fatal stop also ends the binary
grep -q "SOME TESTS FAILED" "$LOG" \
    && { echo "Simulation failed, see $LOG"; exit 1; } \
    || { echo "Simulation passed, see $LOG"; exit 0; }

//--- testbench/tb_loong_decode.sv
module tb_loong_decode;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_INSTR    = 1000;
    localparam int          NUM_DIRECTED = 15;
    localparam logic [31:0] SEED         = 32'h0a76c41d;

    typedef struct packed {
        logic                        illegal;
        decode_pkg::addr_t           pc;
        decode_pkg::alu_op_t         op;
        decode_pkg::alu_sel_t        sel;
        decode_pkg::data_t           imm;
        logic [1:0]                  rd_valid;
        decode_pkg::reg_addr_t [1:0] rd_addr;
        logic                        wr_valid;
        decode_pkg::reg_addr_t       wr_addr;
        logic [31:0]                 push_cyc;
        logic                        exact;
    } dec_rec_t;

    logic                        clk;
    logic                        rst_i;
    logic                        fetch_valid_i;
    decode_pkg::instr_t          fetch_instr_i;
    decode_pkg::addr_t           fetch_pc_i;
    logic                        fetch_credit_o;
    logic                        dispatch_credit_i;
    logic                        dec_valid_o;
    logic                        dec_illegal_o;
    decode_pkg::addr_t           dec_pc_o;
    decode_pkg::alu_op_t         dec_alu_op_o;
    decode_pkg::alu_sel_t        dec_alu_sel_o;
    decode_pkg::data_t           dec_imm_o;
    logic [1:0]                  dec_reg_read_valid_o;
    decode_pkg::reg_addr_t [1:0] dec_reg_read_addr_o;
    logic                        dec_reg_write_valid_o;
    decode_pkg::reg_addr_t       dec_reg_write_addr_o;

    dec_rec_t          exp_q[$];
    int                cycle;
    int                sent_count;
    int                dec_count;
    int                returned_count;
    int                fetch_credits;
    logic              random_dispatch;
    decode_pkg::addr_t next_pc;

    loong_decode_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            stop_on_failure($sformatf("ERROR at %0t: %s expected 0x%0h, got 0x%0h",
                                      $time, name, expected, actual));
    endtask

    // Expected record from the instruction formats of each group
    function automatic dec_rec_t ref_decode(input decode_pkg::instr_t w,
                                            input decode_pkg::addr_t pc);
        dec_rec_t r;
        logic     is_3r;
        logic     is_imm;
        r      = '0;
        r.pc   = pc;
        is_3r  = 1'b1;
        is_imm = 1'b1;
        case (w[31:15])
            decode_pkg::OPC_ADD_W: {r.op, r.sel} = {decode_pkg::OP_ADD, decode_pkg::SEL_ARITH};
            decode_pkg::OPC_SUB_W: {r.op, r.sel} = {decode_pkg::OP_SUB, decode_pkg::SEL_ARITH};
            decode_pkg::OPC_AND:   {r.op, r.sel} = {decode_pkg::OP_AND, decode_pkg::SEL_LOGIC};
            decode_pkg::OPC_OR:    {r.op, r.sel} = {decode_pkg::OP_OR, decode_pkg::SEL_LOGIC};
            decode_pkg::OPC_XOR:   {r.op, r.sel} = {decode_pkg::OP_XOR, decode_pkg::SEL_LOGIC};
            default: is_3r = 1'b0;
        endcase
        case (w[31:22])
            decode_pkg::OPC_ADDI_W: begin
                {r.op, r.sel} = {decode_pkg::OP_ADD, decode_pkg::SEL_ARITH};
                r.imm = {{20{w[21]}}, w[21:10]};
            end
            decode_pkg::OPC_ANDI: {r.op, r.sel, r.imm} = {decode_pkg::OP_AND,
                                   decode_pkg::SEL_LOGIC, 20'd0, w[21:10]};
            decode_pkg::OPC_ORI:  {r.op, r.sel, r.imm} = {decode_pkg::OP_OR,
                                   decode_pkg::SEL_LOGIC, 20'd0, w[21:10]};
            decode_pkg::OPC_XORI: {r.op, r.sel, r.imm} = {decode_pkg::OP_XOR,
                                   decode_pkg::SEL_LOGIC, 20'd0, w[21:10]};
            default: is_imm = 1'b0;
        endcase
        r.wr_valid = 1'b1;
        r.wr_addr  = w[4:0];
        if (w[31:24] == decode_pkg::OPC_CSR) begin
            r.sel = decode_pkg::SEL_CSR;
            r.imm = {18'd0, w[23:10]};
            if (w[9:5] == decode_pkg::RJ_CSRRD) begin
                r.op = decode_pkg::OP_CSRRD;
            end else if (w[9:5] == decode_pkg::RJ_CSRWR) begin
                r.op       = decode_pkg::OP_CSRWR;
                r.rd_valid = 2'b01;
                r.rd_addr  = {5'd0, w[4:0]};
            end else begin
                r.op       = decode_pkg::OP_CSRXCHG;
                r.rd_valid = 2'b11;
                r.rd_addr  = {w[9:5], w[4:0]};
            end
        end else if (is_3r) begin
            r.rd_valid = 2'b11;
            r.rd_addr  = {w[9:5], w[14:10]};
        end else if (is_imm) begin
            r.rd_valid = 2'b10;
            r.rd_addr  = {w[9:5], 5'd0};
        end else begin
            // Unclaimed word keeps only its pc
            r         = '0;
            r.pc      = pc;
            r.illegal = 1'b1;
            r.op      = decode_pkg::OP_NOP;
            r.sel     = decode_pkg::SEL_NOP;
        end
        return r;
    endfunction

    function automatic decode_pkg::instr_t directed_instr(input int idx);
        case (idx)
            0:  return {decode_pkg::OPC_CSR, 14'h0005, 5'd0, 5'd3};
            1:  return {decode_pkg::OPC_CSR, 14'h3fff, 5'd1, 5'd7};
            2:  return {decode_pkg::OPC_CSR, 14'h0180, 5'd12, 5'd31};
            3:  return {decode_pkg::OPC_ADD_W, 5'd2, 5'd4, 5'd6};
            4:  return {decode_pkg::OPC_SUB_W, 5'd31, 5'd0, 5'd17};
            5:  return {decode_pkg::OPC_AND, 5'd8, 5'd9, 5'd10};
            6:  return {decode_pkg::OPC_OR, 5'd11, 5'd12, 5'd13};
            7:  return {decode_pkg::OPC_XOR, 5'd14, 5'd15, 5'd16};
            // Negative and positive addi.w immediates
            8:  return {decode_pkg::OPC_ADDI_W, 12'hff8, 5'd9, 5'd10};
            9:  return {decode_pkg::OPC_ADDI_W, 12'h7ff, 5'd1, 5'd2};
            10: return {decode_pkg::OPC_ANDI, 12'h800, 5'd3, 5'd4};
            11: return {decode_pkg::OPC_ORI, 12'hfff, 5'd5, 5'd6};
            12: return {decode_pkg::OPC_XORI, 12'h123, 5'd7, 5'd8};
            13: return 32'hffff_ffff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    // Mix of all groups, rj biased toward the csrrd and csrwr selectors
    function automatic decode_pkg::instr_t random_instr(input logic [31:0] a,
                                                        input logic [31:0] b);
        logic [4:0] rj;
        rj = (a[29:28] == 2'd0) ? 5'd0 : (a[29:28] == 2'd1) ? 5'd1 : a[9:5];
        case (a[31:30])
            2'd0: return {decode_pkg::OPC_CSR, b[13:0], rj, a[4:0]};
            2'd1: begin
                case (b[2:0])
                    3'd0:    return {decode_pkg::OPC_ADD_W, a[14:0]};
                    3'd1:    return {decode_pkg::OPC_SUB_W, a[14:0]};
                    3'd2:    return {decode_pkg::OPC_AND, a[14:0]};
                    3'd3:    return {decode_pkg::OPC_OR, a[14:0]};
                    default: return {decode_pkg::OPC_XOR, a[14:0]};
                endcase
            end
            2'd2: begin
                case (b[1:0])
                    2'd0:    return {decode_pkg::OPC_ADDI_W, a[21:0]};
                    2'd1:    return {decode_pkg::OPC_ANDI, a[21:0]};
                    2'd2:    return {decode_pkg::OPC_ORI, a[21:0]};
                    default: return {decode_pkg::OPC_XORI, a[21:0]};
                endcase
            end
            default: return b;
        endcase
    endfunction

    // One fetch cycle, sends only while a credit is held
    task automatic fetch_cycle(input logic want, input decode_pkg::instr_t w,
                               input logic exact, output logic sent);
        dec_rec_t    rec;
        logic [31:0] push_cyc;
        @(negedge clk);
        if (fetch_credit_o) fetch_credits++;
        assert (fetch_credits <= decode_pkg::FIFO_DEPTH) else
            stop_on_failure("Fetch holds more credits than buffer entries");
        push_cyc = cycle + 1;
        @(posedge clk);
        sent = want && (fetch_credits > 0);
        fetch_valid_i <= sent;
        if (sent) begin
            rec          = ref_decode(w, next_pc);
            rec.push_cyc = push_cyc;
            rec.exact    = exact;
            exp_q.push_back(rec);
            fetch_instr_i <= w;
            fetch_pc_i    <= next_pc;
            next_pc        = next_pc + 4;
            fetch_credits--;
            sent_count++;
        end
    endtask

    initial begin
        logic [31:0] rng;
        logic [31:0] a;
        logic [31:0] b;
        logic        sent;
        rst_i           <= 1'b1;
        fetch_valid_i   <= 1'b0;
        fetch_instr_i   <= '0;
        fetch_pc_i      <= '0;
        random_dispatch <= 1'b0;
        fetch_credits    = decode_pkg::FIFO_DEPTH;
        next_pc          = 32'h1c00_0000;
        rng              = SEED;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_value("dec_valid_o", 32'd0, 32'(dec_valid_o));
        check_value("fetch_credit_o", 32'd0, 32'(fetch_credit_o));
        @(posedge clk);

        // One at a time, so every record must take exactly two cycles
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            sent = 1'b0;
            while (!sent) fetch_cycle(1'b1, directed_instr(i), 1'b1, sent);
            while (dec_count != sent_count) fetch_cycle(1'b0, '0, 1'b0, sent);
        end

        random_dispatch <= 1'b1;
        for (int i = NUM_DIRECTED; i < NUM_INSTR; i++) begin
            rng = xorshift32(rng);
            a   = rng;
            rng = xorshift32(rng);
            b   = rng;
            sent = 1'b0;
            while (!sent) begin
                rng = xorshift32(rng);
                fetch_cycle(rng[1:0] != 2'b00, random_instr(a, b), 1'b0, sent);
            end
        end

        while (dec_count != sent_count) fetch_cycle(1'b0, '0, 1'b0, sent);
        repeat (2) fetch_cycle(1'b0, '0, 1'b0, sent);
        if (exp_q.size() == 0 && fetch_credits == decode_pkg::FIFO_DEPTH) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_on_failure("Records or fetch credits are missing at the end of the run");
        end
    end

    // Dispatch returns credits, with long pauses in the random phase
    initial begin
        logic [31:0] drng;
        int          pause;
        logic        give;
        drng  = xorshift32(SEED ^ 32'h5bd1_e995);
        pause = 0;
        dispatch_credit_i <= 1'b0;
        forever begin
            @(posedge clk);
            give = 1'b0;
            drng = xorshift32(drng);
            if (pause > 0) begin
                pause--;
            end else if (random_dispatch && drng[5:0] == 6'd0) begin
                pause = 20 + int'(drng[11:6]);
            end else if (dec_count > returned_count) begin
                give = !random_dispatch || drng[12];
            end
            dispatch_credit_i <= give;
            if (give) returned_count++;
        end
    end

    always @(negedge clk) begin
        dec_rec_t rec;
        if (!rst_i && dec_valid_o === 1'b1) begin
            assert (exp_q.size() != 0) else
                stop_on_failure("dec_valid_o is high with no instruction outstanding");
            rec = exp_q.pop_front();
            dec_count++;
            assert (dec_count <= decode_pkg::DISPATCH_CREDITS + returned_count) else
                stop_on_failure("More records dispatched than credits granted");
            check_value("dec_pc_o", rec.pc, dec_pc_o);
            check_value("dec_illegal_o", 32'(rec.illegal), 32'(dec_illegal_o));
            check_value("dec_alu_op_o", 32'(rec.op), 32'(dec_alu_op_o));
            check_value("dec_alu_sel_o", 32'(rec.sel), 32'(dec_alu_sel_o));
            check_value("dec_imm_o", rec.imm, dec_imm_o);
            check_value("dec_reg_read_valid_o", 32'(rec.rd_valid), 32'(dec_reg_read_valid_o));
            check_value("dec_reg_read_addr_o[1]", 32'(rec.rd_addr[1]),
                        32'(dec_reg_read_addr_o[1]));
            check_value("dec_reg_read_addr_o[0]", 32'(rec.rd_addr[0]),
                        32'(dec_reg_read_addr_o[0]));
            check_value("dec_reg_write_valid_o", 32'(rec.wr_valid),
                        32'(dec_reg_write_valid_o));
            check_value("dec_reg_write_addr_o", 32'(rec.wr_addr), 32'(dec_reg_write_addr_o));
            if (rec.exact) begin
                check_value("push to dec_valid_o latency", 32'd2, cycle - rec.push_cyc);
            end else begin
                assert (cycle - rec.push_cyc >= 2) else
                    stop_on_failure("Record came out less than two cycles after its push");
            end
        end
    end

    // Watchdog sized for the worst case per instruction
    initial begin
        repeat (NUM_INSTR * 40) @(posedge clk);
        stop_on_failure("Timeout: the run did not finish within the watchdog limit");
    end

endmodule

//--- verilog/loong_decode_top.sv
module loong_decode_top (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        fetch_valid_i,
    input  decode_pkg::instr_t          fetch_instr_i,
    input  decode_pkg::addr_t           fetch_pc_i,
    output logic                        fetch_credit_o,
    input  logic                        dispatch_credit_i,
    output logic                        dec_valid_o,
    output logic                        dec_illegal_o,
    output decode_pkg::addr_t           dec_pc_o,
    output decode_pkg::alu_op_t         dec_alu_op_o,
    output decode_pkg::alu_sel_t        dec_alu_sel_o,
    output decode_pkg::data_t           dec_imm_o,
    output logic [1:0]                  dec_reg_read_valid_o,
    output decode_pkg::reg_addr_t [1:0] dec_reg_read_addr_o,
    output logic                        dec_reg_write_valid_o,
    output decode_pkg::reg_addr_t       dec_reg_write_addr_o
);

    logic               head_valid;
    decode_pkg::instr_t head_instr;
    decode_pkg::addr_t  head_pc;
    logic               pop;

    instr_fifo fifo_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .push_valid_i (fetch_valid_i),
        .push_instr_i (fetch_instr_i),
        .push_pc_i    (fetch_pc_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_instr_o (head_instr),
        .head_pc_o    (head_pc),
        .credit_o     (fetch_credit_o)
    );

    decode_stage stage_i (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .head_valid_i          (head_valid),
        .head_instr_i          (head_instr),
        .head_pc_i             (head_pc),
        .dispatch_credit_i     (dispatch_credit_i),
        .pop_o                 (pop),
        .dec_valid_o           (dec_valid_o),
        .dec_illegal_o         (dec_illegal_o),
        .dec_pc_o              (dec_pc_o),
        .dec_alu_op_o          (dec_alu_op_o),
        .dec_alu_sel_o         (dec_alu_sel_o),
        .dec_imm_o             (dec_imm_o),
        .dec_reg_read_valid_o  (dec_reg_read_valid_o),
        .dec_reg_read_addr_o   (dec_reg_read_addr_o),
        .dec_reg_write_valid_o (dec_reg_write_valid_o),
        .dec_reg_write_addr_o  (dec_reg_write_addr_o)
    );

endmodule

//--- verilog/decode_stage.sv
module decode_stage (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        head_valid_i,
    input  decode_pkg::instr_t          head_instr_i,
    input  decode_pkg::addr_t           head_pc_i,
    input  logic                        dispatch_credit_i,
    output logic                        pop_o,
    output logic                        dec_valid_o,
    output logic                        dec_illegal_o,
    output decode_pkg::addr_t           dec_pc_o,
    output decode_pkg::alu_op_t         dec_alu_op_o,
    output decode_pkg::alu_sel_t        dec_alu_sel_o,
    output decode_pkg::data_t           dec_imm_o,
    output logic [1:0]                  dec_reg_read_valid_o,
    output decode_pkg::reg_addr_t [1:0] dec_reg_read_addr_o,
    output logic                        dec_reg_write_valid_o,
    output decode_pkg::reg_addr_t       dec_reg_write_addr_o
);

    decode_if csr_res ();
    decode_if alu_3r_res ();
    decode_if alu_2ri12_res ();

    decoder_csr csr_dec_i (
        .instr_i  (head_instr_i),
        .result_o (csr_res.decoder)
    );

    decoder_alu_3r alu_3r_dec_i (
        .instr_i  (head_instr_i),
        .result_o (alu_3r_res.decoder)
    );

    decoder_alu_2ri12 alu_2ri12_dec_i (
        .instr_i  (head_instr_i),
        .result_o (alu_2ri12_res.decoder)
    );

    decode_pkg::credit_cnt_t     credits;
    logic                        illegal;
    logic [1:0]                  read_valid;
    decode_pkg::reg_addr_t [1:0] read_addr;
    logic                        write_valid;
    decode_pkg::reg_addr_t       write_addr;
    decode_pkg::data_t           imm;
    decode_pkg::alu_op_t         alu_op;
    decode_pkg::alu_sel_t        alu_sel;

    // Opcode spaces are disjoint, so at most one decoder claims the word
    always_comb begin
        illegal     = 1'b0;
        read_valid  = 2'b00;
        read_addr   = '0;
        write_valid = 1'b0;
        write_addr  = '0;
        imm         = '0;
        alu_op      = decode_pkg::OP_NOP;
        alu_sel     = decode_pkg::SEL_NOP;
        if (csr_res.result_valid) begin
            read_valid  = csr_res.reg_read_valid;
            read_addr   = csr_res.reg_read_addr;
            write_valid = csr_res.reg_write_valid;
            write_addr  = csr_res.reg_write_addr;
            imm         = csr_res.imm;
            alu_op      = csr_res.alu_op;
            alu_sel     = csr_res.alu_sel;
        end else if (alu_3r_res.result_valid) begin
            read_valid  = alu_3r_res.reg_read_valid;
            read_addr   = alu_3r_res.reg_read_addr;
            write_valid = alu_3r_res.reg_write_valid;
            write_addr  = alu_3r_res.reg_write_addr;
            imm         = alu_3r_res.imm;
            alu_op      = alu_3r_res.alu_op;
            alu_sel     = alu_3r_res.alu_sel;
        end else if (alu_2ri12_res.result_valid) begin
            read_valid  = alu_2ri12_res.reg_read_valid;
            read_addr   = alu_2ri12_res.reg_read_addr;
            write_valid = alu_2ri12_res.reg_write_valid;
            write_addr  = alu_2ri12_res.reg_write_addr;
            imm         = alu_2ri12_res.imm;
            alu_op      = alu_2ri12_res.alu_op;
            alu_sel     = alu_2ri12_res.alu_sel;
        end else begin
            illegal = 1'b1;
        end
    end

    // Credit is taken at pop, the record shows up one cycle later
    assign pop_o = head_valid_i && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            credits     <= decode_pkg::credit_cnt_t'(decode_pkg::DISPATCH_CREDITS);
            dec_valid_o <= 1'b0;
        end else begin
            credits <= credits - decode_pkg::credit_cnt_t'(pop_o)
                               + decode_pkg::credit_cnt_t'(dispatch_credit_i);
            dec_valid_o <= pop_o;
        end
    end

    // Record payload
    always_ff @(posedge clk) begin
        if (pop_o) begin
            dec_illegal_o         <= illegal;
            dec_pc_o              <= head_pc_i;
            dec_alu_op_o          <= alu_op;
            dec_alu_sel_o         <= alu_sel;
            dec_imm_o             <= imm;
            dec_reg_read_valid_o  <= read_valid;
            dec_reg_read_addr_o   <= read_addr;
            dec_reg_write_valid_o <= write_valid;
            dec_reg_write_addr_o  <= write_addr;
        end
    end

endmodule

//--- verilog/decoder_alu_2ri12.sv
// 2RI12 format is {opcode[10], si12[12], rj[5], rd[5]}
module decoder_alu_2ri12 (
    input decode_pkg::instr_t instr_i,
    decode_if.decoder         result_o
);

    decode_pkg::reg_addr_t rd;
    decode_pkg::reg_addr_t rj;
    logic [11:0]           imm12;
    decode_pkg::data_t     imm_sext;
    decode_pkg::data_t     imm_zext;

    assign rd       = instr_i[4:0];
    assign rj       = instr_i[9:5];
    assign imm12    = instr_i[21:10];
    assign imm_sext = {{20{imm12[11]}}, imm12};
    assign imm_zext = {20'b0, imm12};

    always_comb begin
        result_o.result_valid    = 1'b0;
        result_o.reg_read_valid  = 2'b00;
        result_o.reg_read_addr   = '0;
        result_o.reg_write_valid = 1'b0;
        result_o.reg_write_addr  = '0;
        result_o.imm             = '0;
        result_o.alu_op          = decode_pkg::OP_NOP;
        result_o.alu_sel         = decode_pkg::SEL_NOP;

        case (instr_i[31:22])
            decode_pkg::OPC_ADDI_W: begin
                result_o.result_valid = 1'b1;
                result_o.imm          = imm_sext;
                result_o.alu_op       = decode_pkg::OP_ADD;
                result_o.alu_sel      = decode_pkg::SEL_ARITH;
            end
            // Logic immediates are unsigned
            decode_pkg::OPC_ANDI: begin
                result_o.result_valid = 1'b1;
                result_o.imm          = imm_zext;
                result_o.alu_op       = decode_pkg::OP_AND;
                result_o.alu_sel      = decode_pkg::SEL_LOGIC;
            end
            decode_pkg::OPC_ORI: begin
                result_o.result_valid = 1'b1;
                result_o.imm          = imm_zext;
                result_o.alu_op       = decode_pkg::OP_OR;
                result_o.alu_sel      = decode_pkg::SEL_LOGIC;
            end
            decode_pkg::OPC_XORI: begin
                result_o.result_valid = 1'b1;
                result_o.imm          = imm_zext;
                result_o.alu_op       = decode_pkg::OP_XOR;
                result_o.alu_sel      = decode_pkg::SEL_LOGIC;
            end
            default: ;
        endcase

        // rj only, in its own slot
        if (result_o.result_valid) begin
            result_o.reg_read_valid   = 2'b10;
            result_o.reg_read_addr[1] = rj;
            result_o.reg_write_valid  = 1'b1;
            result_o.reg_write_addr   = rd;
        end
    end

endmodule

//--- verilog/decoder_alu_3r.sv
// 3R format is {opcode[17], rk[5], rj[5], rd[5]}
module decoder_alu_3r (
    input decode_pkg::instr_t instr_i,
    decode_if.decoder         result_o
);

    decode_pkg::reg_addr_t rd;
    decode_pkg::reg_addr_t rj;
    decode_pkg::reg_addr_t rk;

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];
    assign rk = instr_i[14:10];

    always_comb begin
        result_o.result_valid    = 1'b0;
        result_o.reg_read_valid  = 2'b00;
        result_o.reg_read_addr   = '0;
        result_o.reg_write_valid = 1'b0;
        result_o.reg_write_addr  = '0;
        result_o.imm             = '0;
        result_o.alu_op          = decode_pkg::OP_NOP;
        result_o.alu_sel         = decode_pkg::SEL_NOP;

        case (instr_i[31:15])
            decode_pkg::OPC_ADD_W: begin
                result_o.result_valid = 1'b1;
                result_o.alu_op       = decode_pkg::OP_ADD;
                result_o.alu_sel      = decode_pkg::SEL_ARITH;
            end
            decode_pkg::OPC_SUB_W: begin
                result_o.result_valid = 1'b1;
                result_o.alu_op       = decode_pkg::OP_SUB;
                result_o.alu_sel      = decode_pkg::SEL_ARITH;
            end
            decode_pkg::OPC_AND: begin
                result_o.result_valid = 1'b1;
                result_o.alu_op       = decode_pkg::OP_AND;
                result_o.alu_sel      = decode_pkg::SEL_LOGIC;
            end
            decode_pkg::OPC_OR: begin
                result_o.result_valid = 1'b1;
                result_o.alu_op       = decode_pkg::OP_OR;
                result_o.alu_sel      = decode_pkg::SEL_LOGIC;
            end
            decode_pkg::OPC_XOR: begin
                result_o.result_valid = 1'b1;
                result_o.alu_op       = decode_pkg::OP_XOR;
                result_o.alu_sel      = decode_pkg::SEL_LOGIC;
            end
            default: ;
        endcase

        // Same register usage for the whole group
        if (result_o.result_valid) begin
            result_o.reg_read_valid   = 2'b11;
            result_o.reg_read_addr[1] = rj;
            result_o.reg_read_addr[0] = rk;
            result_o.reg_write_valid  = 1'b1;
            result_o.reg_write_addr   = rd;
        end
    end

endmodule

//--- verilog/decoder_csr.sv
// CSR format is {opcode[8], csr_num[14], rj[5], rd[5]}
module decoder_csr (
    input decode_pkg::instr_t instr_i,
    decode_if.decoder         result_o
);

    decode_pkg::reg_addr_t rd;
    decode_pkg::reg_addr_t rj;
    logic [13:0]           csr_num;

    assign rd      = instr_i[4:0];
    assign rj      = instr_i[9:5];
    assign csr_num = instr_i[23:10];

    always_comb begin
        // Unclaimed result stays all zero
        result_o.result_valid    = 1'b0;
        result_o.reg_read_valid  = 2'b00;
        result_o.reg_read_addr   = '0;
        result_o.reg_write_valid = 1'b0;
        result_o.reg_write_addr  = '0;
        result_o.imm             = '0;
        result_o.alu_op          = decode_pkg::OP_NOP;
        result_o.alu_sel         = decode_pkg::SEL_NOP;

        if (instr_i[31:24] == decode_pkg::OPC_CSR) begin
            result_o.result_valid    = 1'b1;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.imm             = {18'b0, csr_num};
            result_o.alu_sel         = decode_pkg::SEL_CSR;
            case (rj)
                decode_pkg::RJ_CSRRD: begin
                    result_o.alu_op = decode_pkg::OP_CSRRD;
                end
                decode_pkg::RJ_CSRWR: begin
                    // Old rd value goes out through the rk slot
                    result_o.alu_op           = decode_pkg::OP_CSRWR;
                    result_o.reg_read_valid   = 2'b01;
                    result_o.reg_read_addr[0] = rd;
                end
                default: begin
                    // rj is the write mask
                    result_o.alu_op           = decode_pkg::OP_CSRXCHG;
                    result_o.reg_read_valid   = 2'b11;
                    result_o.reg_read_addr[1] = rj;
                    result_o.reg_read_addr[0] = rd;
                end
            endcase
        end
    end

endmodule

//--- verilog/instr_fifo.sv
module instr_fifo (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               push_valid_i,
    input  decode_pkg::instr_t push_instr_i,
    input  decode_pkg::addr_t  push_pc_i,
    input  logic               pop_i,
    output logic               head_valid_o,
    output decode_pkg::instr_t head_instr_o,
    output decode_pkg::addr_t  head_pc_o,
    output logic               credit_o
);

    decode_pkg::instr_t    mem_instr [decode_pkg::FIFO_DEPTH];
    decode_pkg::addr_t     mem_pc    [decode_pkg::FIFO_DEPTH];
    decode_pkg::fifo_ptr_t wr_ptr;
    decode_pkg::fifo_ptr_t rd_ptr;
    decode_pkg::fifo_cnt_t count;

    logic full;
    logic do_push;
    logic do_pop;

    assign full    = (count == decode_pkg::fifo_cnt_t'(decode_pkg::FIFO_DEPTH));
    assign do_push = push_valid_i && !full;
    assign do_pop  = pop_i && head_valid_o;

    assign head_valid_o = (count != '0);
    assign head_instr_o = mem_instr[rd_ptr];
    assign head_pc_o    = mem_pc[rd_ptr];

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_instr[wr_ptr] <= push_instr_i;
            mem_pc[wr_ptr]    <= push_pc_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + decode_pkg::fifo_cnt_t'(do_push)
                           - decode_pkg::fifo_cnt_t'(do_pop);
            // One credit back to fetch per freed entry
            credit_o <= do_pop;
        end
    end

endmodule

//--- verilog/decode_if.sv
interface decode_if;

    logic                          result_valid;
    // Bit 1 is the rj slot, bit 0 the rk slot
    logic [1:0]                    reg_read_valid;
    decode_pkg::reg_addr_t [1:0]   reg_read_addr;
    logic                          reg_write_valid;
    decode_pkg::reg_addr_t         reg_write_addr;
    decode_pkg::data_t             imm;
    decode_pkg::alu_op_t           alu_op;
    decode_pkg::alu_sel_t          alu_sel;

    modport decoder (
        output result_valid, reg_read_valid, reg_read_addr,
        output reg_write_valid, reg_write_addr, imm, alu_op, alu_sel
    );

    modport stage (
        input result_valid, reg_read_valid, reg_read_addr,
        input reg_write_valid, reg_write_addr, imm, alu_op, alu_sel
    );

endinterface

//--- verilog/decode_pkg.sv
package decode_pkg;

    // Widths with a meaning
    typedef logic [31:0] instr_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  alu_op_t;
    typedef logic [2:0]  alu_sel_t;

    // Buffer and credit sizing
    localparam int FIFO_DEPTH       = 4;
    localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W       = $clog2(FIFO_DEPTH + 1);
    localparam int DISPATCH_CREDITS = 2;
    localparam int CREDIT_W         = $clog2(DISPATCH_CREDITS + 1);

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
    typedef logic [CREDIT_W-1:0]   credit_cnt_t;

    // Operation codes
    localparam alu_op_t OP_NOP     = 8'h00;
    localparam alu_op_t OP_CSRRD   = 8'h01;
    localparam alu_op_t OP_CSRWR   = 8'h02;
    localparam alu_op_t OP_CSRXCHG = 8'h03;
    localparam alu_op_t OP_ADD     = 8'h10;
    localparam alu_op_t OP_SUB     = 8'h11;
    localparam alu_op_t OP_AND     = 8'h20;
    localparam alu_op_t OP_OR      = 8'h21;
    localparam alu_op_t OP_XOR     = 8'h22;

    // Result classes
    localparam alu_sel_t SEL_NOP   = 3'b000;
    localparam alu_sel_t SEL_LOGIC = 3'b001;
    localparam alu_sel_t SEL_ARITH = 3'b010;
    localparam alu_sel_t SEL_CSR   = 3'b011;

    // CSR group, major opcode in bits 31:24
    localparam logic [7:0] OPC_CSR = 8'b0000_0100;

    // rj selects the CSR variant, anything else is csrxchg
    localparam reg_addr_t RJ_CSRRD = 5'd0;
    localparam reg_addr_t RJ_CSRWR = 5'd1;

    // Three-register group, opcode in bits 31:15
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 12-bit immediate group, opcode in bits 31:22
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI   = 10'h00d;
    localparam logic [9:0] OPC_ORI    = 10'h00e;
    localparam logic [9:0] OPC_XORI   = 10'h00f;

endpackage
